/* rtl/jesd_loop_pkg.sv */
// Link geometry, control characters and sync threshold shared by every block of the loopback
`default_nettype none

package jesd_loop_pkg;

  // ****************************************
  // Sample and lane format
  // ****************************************

  // Every converter sample is carried as a 16-bit word
  localparam int np = 16;

  // Each lane moves four octets per device_clk cycle
  localparam int octets_per_lane = 4;

  // Width of one lane word in bits
  localparam int lane_w = octets_per_lane * 8;

  // ****************************************
  // Path geometry
  // ****************************************

  // Main receive path has four channels spread over four lanes
  localparam int main_m = 4;
  localparam int main_l = 4;
  localparam int main_s = 2;

  // Observation path is half as wide as the main path
  localparam int os_m = 2;
  localparam int os_l = 2;
  localparam int os_s = 2;

  // ****************************************
  // Code-group synchronization
  // ****************************************

  // K28.5 octet sent on every lane while the receiver requests SYNC
  localparam logic [7:0] k_char = 8'hBC;

  // Consecutive all-control words a lane must see before it is aligned
  localparam int sync_count = 4;

endpackage

`default_nettype wire

/* rtl/tpl_framer.sv */
// Transport framer that packs channel samples into lane words, one register stage deep
`timescale 1ns/100ps
`default_nettype none

module tpl_framer #(
  parameter int m = jesd_loop_pkg::main_m,
  parameter int l = jesd_loop_pkg::main_l,
  parameter int s = jesd_loop_pkg::main_s
) (
  input  wire                                    device_clk,
  input  wire                                    rst,
  input  wire                                    enable,
  input  wire  [m*s*jesd_loop_pkg::np-1:0]       data,
  output logic [l*jesd_loop_pkg::lane_w-1:0]     lane_data
);

  // ****************************************
  // Octet bookkeeping
  // ****************************************

  // Octets held by one sample
  localparam int bytes_per_sample = jesd_loop_pkg::np / 8;

  // Octets in the whole frame of one clock cycle
  localparam int n_octets = m * s * bytes_per_sample;

  // Octets carried by one lane word
  localparam int opl = jesd_loop_pkg::octets_per_lane;

  // Frame in lane order, before the register
  logic [l*jesd_loop_pkg::lane_w-1:0] lane_map;

  // ****************************************
  // Lane mapping
  // ****************************************

  // The flattened sample vector is read as an octet stream, channel-major.
  // Sample t of the stream sits at data[np*t +: np], high octet first.
  // Lane k then takes stream octets 4k to 4k+3, the first one in the top
  // bits of the lane word, so the lane is read most significant octet first
  always_comb begin
    lane_map = '0;
    for (int o = 0; o < n_octets; o++) begin
      lane_map[jesd_loop_pkg::lane_w*(o/opl) + 8*(opl-1-(o%opl)) +: 8] =
        data[jesd_loop_pkg::np*(o/bytes_per_sample) +
             8*(bytes_per_sample-1-(o%bytes_per_sample)) +: 8];
    end
  end

  // ****************************************
  // Output register
  // ****************************************

  // A disabled path sends an all-zero frame so the far end sees silence
  always_ff @(posedge device_clk) begin
    if (rst) begin
      lane_data <= '0;
    end else if (!enable) begin
      lane_data <= '0;
    end else begin
      lane_data <= lane_map;
    end
  end

endmodule

`default_nettype wire

/* rtl/link_tx.sv */
// Link transmitter that sends K characters during a SYNC request and framed data afterwards
`timescale 1ns/100ps
`default_nettype none

module link_tx #(
  parameter int l = jesd_loop_pkg::main_l
) (
  input  wire                                             device_clk,
  input  wire                                             rst,
  input  wire                                             sync_req,
  input  wire  [l*jesd_loop_pkg::lane_w-1:0]              lane_data,
  output logic [l*jesd_loop_pkg::lane_w-1:0]              tx_lane_data,
  output logic [l*jesd_loop_pkg::octets_per_lane-1:0]     tx_charisk
);

  // ****************************************
  // Control words
  // ****************************************

  // Number of octets across all lanes in one cycle
  localparam int n_octets = l * jesd_loop_pkg::octets_per_lane;

  // Every octet of every lane carries the sync character
  localparam logic [l*jesd_loop_pkg::lane_w-1:0] k_word = {n_octets{jesd_loop_pkg::k_char}};

  // Control flag for each octet, all set during code-group sync
  localparam logic [n_octets-1:0] k_flags = '1;

  // ****************************************
  // Output register
  // ****************************************

  // The receiver comes out of reset requesting SYNC, so the transmitter
  // starts in the same state and sends control words from the first cycle.
  // Once the request is released the framed lane words pass through with
  // all control flags cleared
  always_ff @(posedge device_clk) begin
    if (rst) begin
      tx_lane_data <= k_word;
      tx_charisk   <= k_flags;
    end else if (sync_req) begin
      tx_lane_data <= k_word;
      tx_charisk   <= k_flags;
    end else begin
      tx_lane_data <= lane_data;
      tx_charisk   <= '0;
    end
  end

  // ****************************************
  // Checks
  // ****************************************

  // Control and data octets are never mixed within one cycle.
  // The receiver relies on this when it qualifies whole words as data
  charisk_uniform_a : assert property (
    @(posedge device_clk) disable iff (rst)
    (tx_charisk == '0) || (tx_charisk == k_flags)
  ) else $error("tx_charisk mixes control and data octets: %h", tx_charisk);

endmodule

`default_nettype wire

/* rtl/link_rx.sv */
// Link receiver that aligns on K characters per lane, drives SYNC and link-up, and marks data
`timescale 1ns/100ps
`default_nettype none

module link_rx #(
  parameter int l = jesd_loop_pkg::main_l
) (
  input  wire                                             device_clk,
  input  wire                                             rst,
  input  wire                                             resync,
  input  wire  [l*jesd_loop_pkg::lane_w-1:0]              tx_lane_data,
  input  wire  [l*jesd_loop_pkg::octets_per_lane-1:0]     tx_charisk,
  output logic [l*jesd_loop_pkg::lane_w-1:0]              rx_lane_data,
  output logic                                            rx_valid,
  output logic                                            sync_req,
  output logic                                            link_up
);

  // ****************************************
  // Declarations
  // ****************************************

  localparam int opl   = jesd_loop_pkg::octets_per_lane;
  localparam int cnt_w = $clog2(jesd_loop_pkg::sync_count + 1);

  // Saturation value of the per-lane counters
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(jesd_loop_pkg::sync_count);

  // Per-lane run length of all-control words
  logic [cnt_w-1:0] k_cnt [l];

  // Lane carries an all-control word this cycle
  logic [l-1:0] lane_k;

  // Lane has seen enough consecutive control words
  logic [l-1:0] lane_aligned;

  // ****************************************
  // Control word detection
  // ****************************************

  // A lane word counts as control only if every octet is flagged and
  // every octet holds the sync character
  always_comb begin
    for (int k = 0; k < l; k++) begin
      lane_k[k] = &tx_charisk[opl*k +: opl];
      for (int o = 0; o < opl; o++) begin
        if (tx_lane_data[jesd_loop_pkg::lane_w*k + 8*o +: 8] != jesd_loop_pkg::k_char) begin
          lane_k[k] = 1'b0;
        end
      end
      lane_aligned[k] = (k_cnt[k] == cnt_max);
    end
  end

  // ****************************************
  // Alignment counters
  // ****************************************

  // While the link is down, a data word breaks the run and the count
  // starts again. Once the link is up the counters simply hold
  always_ff @(posedge device_clk) begin
    for (int k = 0; k < l; k++) begin
      if (rst || resync) begin
        k_cnt[k] <= '0;
      end else if (!link_up) begin
        if (!lane_k[k]) begin
          k_cnt[k] <= '0;
        end else if (k_cnt[k] != cnt_max) begin
          k_cnt[k] <= k_cnt[k] + 1'b1;
        end
      end
    end
  end

  // ****************************************
  // Link state
  // ****************************************

  // All lanes aligned releases SYNC and brings the link up together.
  // A resync pulse drops the link and requests SYNC on the next cycle
  always_ff @(posedge device_clk) begin
    if (rst || resync) begin
      link_up  <= 1'b0;
      sync_req <= 1'b1;
    end else if (!link_up && (&lane_aligned)) begin
      link_up  <= 1'b1;
      sync_req <= 1'b0;
    end
  end

  // ****************************************
  // Data stage
  // ****************************************

  always_ff @(posedge device_clk) begin
    rx_lane_data <= tx_lane_data;
  end

  // Data is unmasked only on data words of a live link, and a resync in
  // the same cycle masks it as well so valid never outlives link-up
  always_ff @(posedge device_clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= link_up && !resync && (tx_charisk == '0);
    end
  end

  // ****************************************
  // Checks
  // ****************************************

  valid_needs_link_a : assert property (
    @(posedge device_clk) disable iff (rst)
    rx_valid |-> link_up
  ) else $error("rx_valid high while link_up is low");

  // The SYNC request and link-up are exclusive states of the loop
  sync_excl_a : assert property (
    @(posedge device_clk) disable iff (rst)
    !(sync_req && link_up)
  ) else $error("sync_req and link_up both high");

endmodule

`default_nettype wire

/* rtl/tpl_deframer.sv */
// Transport deframer that restores channel samples from lane words with a valid strobe
`timescale 1ns/100ps
`default_nettype none

module tpl_deframer #(
  parameter int m = jesd_loop_pkg::main_m,
  parameter int l = jesd_loop_pkg::main_l,
  parameter int s = jesd_loop_pkg::main_s
) (
  input  wire                                  device_clk,
  input  wire                                  rst,
  input  wire  [l*jesd_loop_pkg::lane_w-1:0]   rx_lane_data,
  input  wire                                  rx_valid,
  output logic [m*s*jesd_loop_pkg::np-1:0]     samples,
  output logic                                 valid
);

  // ****************************************
  // Octet bookkeeping
  // ****************************************

  localparam int bytes_per_sample = jesd_loop_pkg::np / 8;
  localparam int n_octets         = m * s * bytes_per_sample;
  localparam int opl              = jesd_loop_pkg::octets_per_lane;

  // Samples in channel-major order, before the register
  logic [m*s*jesd_loop_pkg::np-1:0] sample_map;

  // ****************************************
  // Lane unmapping
  // ****************************************

  // Exact inverse of the framer.
  // Stream octet o comes from lane o/4, counted from the top of the word,
  // and lands in sample o/2 with the even octet as the high byte
  always_comb begin
    sample_map = '0;
    for (int o = 0; o < n_octets; o++) begin
      sample_map[jesd_loop_pkg::np*(o/bytes_per_sample) +
                 8*(bytes_per_sample-1-(o%bytes_per_sample)) +: 8] =
        rx_lane_data[jesd_loop_pkg::lane_w*(o/opl) + 8*(opl-1-(o%opl)) +: 8];
    end
  end

  // ****************************************
  // Output register
  // ****************************************

  // Samples only load on valid words, so the last good frame stays visible
  always_ff @(posedge device_clk) begin
    if (rx_valid) begin
      samples <= sample_map;
    end
  end

  // Valid moves with the data through the same stage
  always_ff @(posedge device_clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= rx_valid;
    end
  end

endmodule

`default_nettype wire

/* rtl/jesd_loop_top.sv */
// Top level of the loopback that builds the main and observation link paths on device_clk
`timescale 1ns/100ps
`default_nettype none

module jesd_loop_top (
  input  wire                                                             device_clk,
  input  wire                                                             rst,

  input  wire                                                             main_enable,
  input  wire                                                             main_resync,
  input  wire  [jesd_loop_pkg::main_m*jesd_loop_pkg::main_s*jesd_loop_pkg::np-1:0] main_data,
  output wire  [jesd_loop_pkg::main_m*jesd_loop_pkg::main_s*jesd_loop_pkg::np-1:0] main_samples,
  output wire                                                             main_valid,
  output wire                                                             main_link_up,

  input  wire                                                             os_enable,
  input  wire                                                             os_resync,
  input  wire  [jesd_loop_pkg::os_m*jesd_loop_pkg::os_s*jesd_loop_pkg::np-1:0]     os_data,
  output wire  [jesd_loop_pkg::os_m*jesd_loop_pkg::os_s*jesd_loop_pkg::np-1:0]     os_samples,
  output wire                                                             os_valid,
  output wire                                                             os_link_up
);

  // ****************************************
  // Main path
  // ****************************************

  wire [jesd_loop_pkg::main_l*jesd_loop_pkg::lane_w-1:0]          main_lane_data;
  wire [jesd_loop_pkg::main_l*jesd_loop_pkg::lane_w-1:0]          main_tx_lane_data;
  wire [jesd_loop_pkg::main_l*jesd_loop_pkg::octets_per_lane-1:0] main_tx_charisk;
  wire [jesd_loop_pkg::main_l*jesd_loop_pkg::lane_w-1:0]          main_rx_lane_data;
  wire                                                            main_rx_valid;
  // SYNC request from the receiver back to the transmitter
  wire                                                            main_sync_req;

  tpl_framer #(
    .m (jesd_loop_pkg::main_m),
    .l (jesd_loop_pkg::main_l),
    .s (jesd_loop_pkg::main_s)
  ) i_main_framer (
    .device_clk (device_clk),
    .rst        (rst),
    .enable     (main_enable),
    .data       (main_data),
    .lane_data  (main_lane_data)
  );

  link_tx #(.l (jesd_loop_pkg::main_l)) i_main_link_tx (
    .device_clk   (device_clk),
    .rst          (rst),
    .sync_req     (main_sync_req),
    .lane_data    (main_lane_data),
    .tx_lane_data (main_tx_lane_data),
    .tx_charisk   (main_tx_charisk)
  );

  link_rx #(.l (jesd_loop_pkg::main_l)) i_main_link_rx (
    .device_clk   (device_clk),
    .rst          (rst),
    .resync       (main_resync),
    .tx_lane_data (main_tx_lane_data),
    .tx_charisk   (main_tx_charisk),
    .rx_lane_data (main_rx_lane_data),
    .rx_valid     (main_rx_valid),
    .sync_req     (main_sync_req),
    .link_up      (main_link_up)
  );

  tpl_deframer #(
    .m (jesd_loop_pkg::main_m),
    .l (jesd_loop_pkg::main_l),
    .s (jesd_loop_pkg::main_s)
  ) i_main_deframer (
    .device_clk   (device_clk),
    .rst          (rst),
    .rx_lane_data (main_rx_lane_data),
    .rx_valid     (main_rx_valid),
    .samples      (main_samples),
    .valid        (main_valid)
  );

  // ****************************************
  // Observation path
  // ****************************************

  wire [jesd_loop_pkg::os_l*jesd_loop_pkg::lane_w-1:0]            os_lane_data;
  wire [jesd_loop_pkg::os_l*jesd_loop_pkg::lane_w-1:0]            os_tx_lane_data;
  wire [jesd_loop_pkg::os_l*jesd_loop_pkg::octets_per_lane-1:0]   os_tx_charisk;
  wire [jesd_loop_pkg::os_l*jesd_loop_pkg::lane_w-1:0]            os_rx_lane_data;
  wire                                                            os_rx_valid;
  wire                                                            os_sync_req;

  tpl_framer #(
    .m (jesd_loop_pkg::os_m),
    .l (jesd_loop_pkg::os_l),
    .s (jesd_loop_pkg::os_s)
  ) i_os_framer (
    .device_clk (device_clk),
    .rst        (rst),
    .enable     (os_enable),
    .data       (os_data),
    .lane_data  (os_lane_data)
  );

  link_tx #(.l (jesd_loop_pkg::os_l)) i_os_link_tx (
    .device_clk   (device_clk),
    .rst          (rst),
    .sync_req     (os_sync_req),
    .lane_data    (os_lane_data),
    .tx_lane_data (os_tx_lane_data),
    .tx_charisk   (os_tx_charisk)
  );

  link_rx #(.l (jesd_loop_pkg::os_l)) i_os_link_rx (
    .device_clk   (device_clk),
    .rst          (rst),
    .resync       (os_resync),
    .tx_lane_data (os_tx_lane_data),
    .tx_charisk   (os_tx_charisk),
    .rx_lane_data (os_rx_lane_data),
    .rx_valid     (os_rx_valid),
    .sync_req     (os_sync_req),
    .link_up      (os_link_up)
  );

  tpl_deframer #(
    .m (jesd_loop_pkg::os_m),
    .l (jesd_loop_pkg::os_l),
    .s (jesd_loop_pkg::os_s)
  ) i_os_deframer (
    .device_clk   (device_clk),
    .rst          (rst),
    .rx_lane_data (os_rx_lane_data),
    .rx_valid     (os_rx_valid),
    .samples      (os_samples),
    .valid        (os_valid)
  );

endmodule

`default_nettype wire

/* verification/jesd_loop_tb.sv */
// Self-checking testbench for the JESD loopback, compiled from build.f with jesd_loop_tb as top
`timescale 1ns/100ps
`default_nettype none

module jesd_loop_tb;

  // ****************************************
  // DUT signals and bookkeeping
  // ****************************************

  localparam int main_w = jesd_loop_pkg::main_m * jesd_loop_pkg::main_s * jesd_loop_pkg::np;
  localparam int os_w   = jesd_loop_pkg::os_m * jesd_loop_pkg::os_s * jesd_loop_pkg::np;
  // Longest time a link may take to come up
  localparam int up_limit = jesd_loop_pkg::sync_count + 4;
  // Framer, transmitter, receiver and deframer each add one cycle
  localparam int latency = 4;

  logic              device_clk;
  logic              rst;
  logic              main_enable;
  logic              main_resync;
  logic [main_w-1:0] main_data;
  wire  [main_w-1:0] main_samples;
  wire               main_valid;
  wire               main_link_up;
  logic              os_enable;
  logic              os_resync;
  logic [os_w-1:0]   os_data;
  wire  [os_w-1:0]   os_samples;
  wire               os_valid;
  wire               os_link_up;

  int          error_count;
  int          test_count;
  int          failed_tests;
  int          main_checks;
  int          os_checks;
  string       cur_test;
  int unsigned main_counter;
  int unsigned os_counter;
  // Levels that the next cycle drives
  bit          drv_rst;
  bit          drv_main_en;
  bit          drv_os_en;
  // Path must stay up and valid on every cycle while set
  bit          expect_main;
  bit          expect_os;

  // The last latency+1 driven vectors, oldest first
  logic [main_w-1:0] main_q [$];
  logic [os_w-1:0]   os_q [$];

  // Test table, one entry per row in every column.
  // row_resync picks the path that gets a resync pulse: 0 none, 1 main, 2 os
  string row_name [$];
  bit    row_main_en [$];
  bit    row_os_en [$];
  int    row_resync [$];
  int    row_cycles [$];
  bit    row_main_up [$];
  bit    row_os_up [$];

  jesd_loop_top uut (
    .device_clk   (device_clk),
    .rst          (rst),
    .main_enable  (main_enable),
    .main_resync  (main_resync),
    .main_data    (main_data),
    .main_samples (main_samples),
    .main_valid   (main_valid),
    .main_link_up (main_link_up),
    .os_enable    (os_enable),
    .os_resync    (os_resync),
    .os_data      (os_data),
    .os_samples   (os_samples),
    .os_valid     (os_valid),
    .os_link_up   (os_link_up)
  );

  initial begin
    device_clk = 1'b0;
    forever #20 device_clk = ~device_clk;
  end

  // ****************************************
  // Stimulus and checking
  // ****************************************

  // Sample j of channel i is base + m*j + i, stored channel-major
  function automatic logic [main_w-1:0] make_pattern(input int m, input int s,
                                                     input int unsigned base);
    logic [main_w-1:0] v;
    logic [15:0]       val;
    v = '0;
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < s; j++) begin
        val = base + m * j + i;
        v[16*(i*s+j) +: 16] = val;
      end
    end
    return v;
  endfunction

  function automatic logic read_status(input bit main_path, input bit want_valid);
    if (main_path) begin
      return want_valid ? main_valid : main_link_up;
    end
    return want_valid ? os_valid : os_link_up;
  endfunction

  task automatic add_row(input string name, input bit me, input bit oe, input int rs,
                         input int cyc, input bit mu, input bit ou);
    row_name.push_back(name);
    row_main_en.push_back(me);
    row_os_en.push_back(oe);
    row_resync.push_back(rs);
    row_cycles.push_back(cyc);
    row_main_up.push_back(mu);
    row_os_up.push_back(ou);
  endtask

  // Outputs are compared at the falling edge, half a cycle after they settle
  task automatic check_outputs;
    if (main_valid === 1'b1) begin
      main_checks++;
      if (main_q.size() < latency + 1) begin
        $display("FAILED %s: main_valid high before any sample could arrive", cur_test);
        error_count++;
      end else if (main_samples !== main_q[0]) begin
        $display("FAILED %s: main_samples got %h expected %h", cur_test, main_samples, main_q[0]);
        error_count++;
      end
    end
    if (os_valid === 1'b1) begin
      os_checks++;
      if (os_q.size() < latency + 1) begin
        $display("FAILED %s: os_valid high before any sample could arrive", cur_test);
        error_count++;
      end else if (os_samples !== os_q[0]) begin
        $display("FAILED %s: os_samples got %h expected %h", cur_test, os_samples, os_q[0]);
        error_count++;
      end
    end
    if (expect_main && (main_link_up !== 1'b1 || main_valid !== 1'b1)) begin
      $display("FAILED %s: main_link_up %h main_valid %h expected 1 1", cur_test,
               main_link_up, main_valid);
      error_count++;
    end
    if (expect_os && (os_link_up !== 1'b1 || os_valid !== 1'b1)) begin
      $display("FAILED %s: os_link_up %h os_valid %h expected 1 1", cur_test,
               os_link_up, os_valid);
      error_count++;
    end
  endtask

  // One clock cycle: drive on the rising edge, then check at the falling edge
  task automatic step_cycle(input bit main_rs, input bit os_rs);
    logic [main_w-1:0] main_v;
    logic [main_w-1:0] os_v;
    @(posedge device_clk);
    main_v = drv_main_en ? make_pattern(jesd_loop_pkg::main_m, jesd_loop_pkg::main_s,
                                        main_counter) : '0;
    os_v = drv_os_en ? make_pattern(jesd_loop_pkg::os_m, jesd_loop_pkg::os_s,
                                    os_counter) : '0;
    // Each counter moves by one whole frame, and only while its path is enabled
    if (drv_main_en) begin
      main_counter += jesd_loop_pkg::main_m * jesd_loop_pkg::main_s;
    end
    if (drv_os_en) begin
      os_counter += jesd_loop_pkg::os_m * jesd_loop_pkg::os_s;
    end
    rst         <= drv_rst;
    main_enable <= drv_main_en;
    main_resync <= main_rs;
    main_data   <= main_v;
    os_enable   <= drv_os_en;
    os_resync   <= os_rs;
    os_data     <= os_v[os_w-1:0];
    main_q.push_back(main_v);
    os_q.push_back(os_v[os_w-1:0]);
    if (main_q.size() > latency + 1) begin
      main_q.delete(0);
    end
    if (os_q.size() > latency + 1) begin
      os_q.delete(0);
    end
    @(negedge device_clk);
    check_outputs();
  endtask

  // Steps until the status reaches the level, giving up after limit cycles
  task automatic wait_level(input bit main_path, input bit want_valid, input bit level,
                            input int limit);
    int    n;
    string what;
    if (main_path) begin
      what = want_valid ? "main_valid" : "main_link_up";
    end else begin
      what = want_valid ? "os_valid" : "os_link_up";
    end
    n = 0;
    while (read_status(main_path, want_valid) !== level && n < limit) begin
      step_cycle(1'b0, 1'b0);
      n++;
    end
    if (read_status(main_path, want_valid) !== level) begin
      $display("FAILED %s: timed out after %0d cycles waiting for %s to become %0b",
               cur_test, limit, what, level);
      error_count++;
    end
  endtask

  task automatic check_reset_state;
    if (main_link_up !== 1'b0 || os_link_up !== 1'b0) begin
      $display("FAILED %s: main_link_up %h os_link_up %h expected 0 0", cur_test,
               main_link_up, os_link_up);
      error_count++;
    end
    if (main_valid !== 1'b0 || os_valid !== 1'b0) begin
      $display("FAILED %s: main_valid %h os_valid %h expected 0 0", cur_test,
               main_valid, os_valid);
      error_count++;
    end
  endtask

  // Pulse resync on one path, see it drop, then see it come back
  task automatic resync_path(input bit main_path);
    if (main_path) begin
      expect_main = 1'b0;
    end else begin
      expect_os = 1'b0;
    end
    step_cycle(main_path, !main_path);
    wait_level(main_path, 1'b0, 1'b0, 3);
    wait_level(main_path, 1'b1, 1'b0, 3);
    wait_level(main_path, 1'b0, 1'b1, up_limit);
    // Valid returns once the first data word has crossed the whole link
    wait_level(main_path, 1'b1, 1'b1, latency);
    expect_main = 1'b1;
    expect_os   = 1'b1;
  endtask

  task automatic finish_test(input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", test_count, cur_test);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_count, cur_test, error_count - errs_before);
    end
  endtask

  task automatic run_row(input int r);
    int errs_before;
    int main_before;
    int os_before;
    cur_test    = row_name[r];
    errs_before = error_count;
    main_before = main_checks;
    os_before   = os_checks;
    drv_main_en = row_main_en[r];
    drv_os_en   = row_os_en[r];
    if (row_resync[r] == 1) begin
      resync_path(1'b1);
    end else if (row_resync[r] == 2) begin
      resync_path(1'b0);
    end
    repeat (row_cycles[r]) step_cycle(1'b0, 1'b0);
    if (main_link_up !== row_main_up[r]) begin
      $display("FAILED %s: main_link_up got %h expected %h", cur_test, main_link_up,
               row_main_up[r]);
      error_count++;
    end
    if (os_link_up !== row_os_up[r]) begin
      $display("FAILED %s: os_link_up got %h expected %h", cur_test, os_link_up, row_os_up[r]);
      error_count++;
    end
    // A disabled path must have flushed to an all-zero frame by now
    if (!drv_main_en && main_samples !== '0) begin
      $display("FAILED %s: main_samples got %h expected 0", cur_test, main_samples);
      error_count++;
    end
    if (!drv_os_en && os_samples !== '0) begin
      $display("FAILED %s: os_samples got %h expected 0", cur_test, os_samples);
      error_count++;
    end
    if (main_checks == main_before || os_checks == os_before) begin
      $display("FAILED %s: a path delivered no valid samples during the test", cur_test);
      error_count++;
    end
    finish_test(errs_before);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int errs_before;
    int up_wait;
    rst          = 1'b1;
    main_enable  = 1'b0;
    main_resync  = 1'b0;
    main_data    = '0;
    os_enable    = 1'b0;
    os_resync    = 1'b0;
    os_data      = '0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    main_checks  = 0;
    os_checks    = 0;
    main_counter = 0;
    os_counter   = 0;
    drv_rst      = 1'b1;
    drv_main_en  = 1'b1;
    drv_os_en    = 1'b1;
    expect_main  = 1'b0;
    expect_os    = 1'b0;

    //      name             main  os  resync  cycles  main up  os up
    add_row("both_enabled",   1,   1,  0,      40,     1,       1);
    add_row("main_disabled",  0,   1,  0,      30,     1,       1);
    add_row("main_reenabled", 1,   1,  0,      20,     1,       1);
    add_row("main_resync",    1,   1,  1,      30,     1,       1);
    add_row("os_resync",      1,   1,  2,      30,     1,       1);
    add_row("both_disabled",  0,   0,  0,      12,     1,       1);

    cur_test    = "reset_state";
    errs_before = error_count;
    repeat (3) begin
      step_cycle(1'b0, 1'b0);
      check_reset_state();
    end
    drv_rst = 1'b0;
    // The cycle that releases reset and the one after it
    repeat (2) begin
      step_cycle(1'b0, 1'b0);
      check_reset_state();
    end
    finish_test(errs_before);

    cur_test    = "link_bring_up";
    errs_before = error_count;
    // Both links leave reset together, so they share one bring-up budget
    up_wait = 0;
    while ((main_link_up !== 1'b1 || os_link_up !== 1'b1) && up_wait < up_limit) begin
      step_cycle(1'b0, 1'b0);
      up_wait++;
    end
    if (main_link_up !== 1'b1 || os_link_up !== 1'b1) begin
      $display("FAILED %s: both links were not up %0d cycles after reset release",
               cur_test, up_limit);
      error_count++;
    end
    wait_level(1'b1, 1'b1, 1'b1, latency);
    wait_level(1'b0, 1'b1, 1'b1, latency);
    expect_main = 1'b1;
    expect_os   = 1'b1;
    finish_test(errs_before);

    for (int r = 0; r < row_name.size(); r++) begin
      run_row(r);
    end

    $display("%0d tests, %0d failed, %0d main and %0d os words checked, %0d errors",
             test_count, failed_tests, main_checks, os_checks, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/jesd_loop_pkg.sv
rtl/tpl_framer.sv
rtl/link_tx.sv
rtl/link_rx.sv
rtl/tpl_deframer.sv
rtl/jesd_loop_top.sv
verification/jesd_loop_tb.sv

/* Bender.yml */
package:
  name: jesd_loop

sources:
  - rtl/jesd_loop_pkg.sv
  - rtl/tpl_framer.sv
  - rtl/link_tx.sv
  - rtl/link_rx.sv
  - rtl/tpl_deframer.sv
  - rtl/jesd_loop_top.sv
  - target: simulation
    files:
      - verification/jesd_loop_tb.sv
